// ==== Bender.yml ====
package:
  name: chiplet_switch

sources:
  - chiplet_types_pkg.sv
  - switch_if.sv
  - arbiter.sv
  - buffers.sv
  - route_compute.sv
  - switch_allocator.sv
  - crossbar.sv
  - switch.sv
  - target: test
    files:
      - tb_switch_assert.sv
      - tb_switch.sv

// ==== arbiter.sv ====
`timescale 1ns/1ps

module arbiter #(
    parameter int WIDTH = 4,
    localparam int SEL_BITS = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [WIDTH-1:0]    bid,
    output logic                valid,
    output logic [SEL_BITS-1:0] select
);
    // Bidder with the highest priority this cycle
    logic [SEL_BITS-1:0] ptr;
    logic found;

    assign valid = |bid;

    // Search upward from the pointer, wrapping around
    always_comb begin
        int idx;
        found = 1'b0;
        select = '0;
        for (int k = 0; k < WIDTH; k++) begin
            idx = (int'(ptr) + k) % WIDTH;
            if (!found && bid[idx]) begin
                found = 1'b1;
                select = SEL_BITS'(idx);
            end
        end
    end

    // Winner drops to lowest priority
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (valid) begin
            ptr <= (select == SEL_BITS'(WIDTH - 1)) ? '0 : select + 1'b1;
        end
    end

endmodule

// ==== buffers.sv ====
`timescale 1ns/1ps

module buffers #(
    parameter int NUM_BUFFERS = 4,
    parameter int NUM_OUTPORTS = 4,
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic rst,
    buffers_if.buffers buf_if
);
    localparam int OUT_BITS = (NUM_OUTPORTS > 1) ? $clog2(NUM_OUTPORTS) : 1;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    chiplet_types_pkg::flit_t mem [NUM_BUFFERS][DEPTH];
    logic [PTR_BITS-1:0] rd_ptr [NUM_BUFFERS];
    logic [PTR_BITS-1:0] wr_ptr [NUM_BUFFERS];
    logic [CNT_BITS-1:0] count [NUM_BUFFERS];

    // Route state of the current head
    logic [NUM_BUFFERS-1:0] routed;
    logic [OUT_BITS-1:0] route [NUM_BUFFERS];

    logic [NUM_BUFFERS-1:0] push;
    logic [NUM_BUFFERS-1:0] pop;

    always_comb begin
        for (int b = 0; b < NUM_BUFFERS; b++) begin
            buf_if.rdata[b] = mem[b][rd_ptr[b]];
            buf_if.empty[b] = (count[b] == '0);
            buf_if.available[b] = (count[b] != CNT_BITS'(DEPTH));
            buf_if.switch_outport[b] = route[b];

            // A head is routed once, then competes for the switch
            buf_if.req_routing[b] = !buf_if.empty[b] && !routed[b];
            buf_if.req_switch[b] = !buf_if.empty[b] && routed[b];

            push[b] = buf_if.wen[b] && buf_if.available[b];
            pop[b] = buf_if.ren[b] && !buf_if.empty[b];
        end
    end

    // Flit storage
    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BUFFERS; b++) begin
            if (push[b]) begin
                mem[b][wr_ptr[b]] <= buf_if.wdata[b];
            end
        end
    end

    // Circular pointers and fill count
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < NUM_BUFFERS; b++) begin
                rd_ptr[b] <= '0;
                wr_ptr[b] <= '0;
                count[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BUFFERS; b++) begin
                if (push[b]) begin
                    wr_ptr[b] <= (wr_ptr[b] == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr[b] + 1'b1;
                end
                if (pop[b]) begin
                    rd_ptr[b] <= (rd_ptr[b] == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr[b] + 1'b1;
                end
                if (push[b] && !pop[b]) begin
                    count[b] <= count[b] + 1'b1;
                end else if (pop[b] && !push[b]) begin
                    count[b] <= count[b] - 1'b1;
                end
            end
        end
    end

    // Next head after a pop must be routed again
    always_ff @(posedge clk) begin
        if (rst) begin
            routed <= '0;
        end else begin
            for (int b = 0; b < NUM_BUFFERS; b++) begin
                if (pop[b]) begin
                    routed[b] <= 1'b0;
                end else if (buf_if.routing_granted[b]) begin
                    routed[b] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BUFFERS; b++) begin
            if (buf_if.routing_granted[b]) begin
                route[b] <= buf_if.routing_outport;
            end
        end
    end

endmodule

// ==== chiplet_types_pkg.sv ====
package chiplet_types_pkg;

    // Node address, one per chiplet on the network
    typedef logic [4:0] node_id_t;

    // Single-flit packet, destination in the top bits
    typedef struct packed {
        node_id_t    dest;
        logic [31:0] payload;
    } flit_t;

    // Format code carried in payload[31:28]
    localparam logic [3:0] FMT_SWITCH_CFG = 4'hC;

    // Route table holds one entry per destination node
    localparam int TABLE_SIZE = 32;
    localparam int OUTPORT_BITS = 3;

    typedef logic [OUTPORT_BITS-1:0] route_entry_t;
    typedef logic [$clog2(TABLE_SIZE)-1:0] table_index_t;

    // Payload field accessors
    function automatic logic [3:0] flit_format(flit_t f);
        return f.payload[31:28];
    endfunction

    function automatic node_id_t cfg_target(flit_t f);
        return f.payload[27:23];
    endfunction

    function automatic table_index_t cfg_index(flit_t f);
        return f.payload[22:18];
    endfunction

    function automatic route_entry_t cfg_outport(flit_t f);
        return f.payload[2:0];
    endfunction

endpackage

// ==== crossbar.sv ====
`timescale 1ns/1ps

module crossbar #(
    parameter int NUM_BUFFERS = 4,
    parameter int NUM_OUTPORTS = 4,
    localparam int OUT_BITS = (NUM_OUTPORTS > 1) ? $clog2(NUM_OUTPORTS) : 1,
    localparam int IDX_BITS = (NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  chiplet_types_pkg::flit_t [NUM_BUFFERS-1:0] rdata,
    input  logic                                       grant_valid,
    input  logic [IDX_BITS-1:0]                        grant_index,
    input  logic [OUT_BITS-1:0]                        grant_outport,
    output logic [NUM_BUFFERS-1:0]                     ren,
    output chiplet_types_pkg::flit_t [NUM_OUTPORTS-1:0] out,
    output logic [NUM_OUTPORTS-1:0]                    valid
);
    // Granted head leaves its buffer at the same edge it is registered
    assign ren = NUM_BUFFERS'(grant_valid) << grant_index;

    // One-cycle strobe on the granted outport only
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (grant_valid) begin
            valid <= NUM_OUTPORTS'(1) << grant_outport;
        end else begin
            valid <= '0;
        end
    end

    // Output data holds until the next flit for that port
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            out[grant_outport] <= rdata[grant_index];
        end
    end

endmodule

// ==== files.f ====
chiplet_types_pkg.sv
switch_if.sv
arbiter.sv
buffers.sv
route_compute.sv
switch_allocator.sv
crossbar.sv
switch.sv
tb_switch_assert.sv
tb_switch.sv

// ==== route_compute.sv ====
`timescale 1ns/1ps

module route_compute #(
    parameter chiplet_types_pkg::node_id_t NODE = 5'd5,
    parameter int NUM_OUTPORTS = 4,
    localparam int OUT_BITS = (NUM_OUTPORTS > 1) ? $clog2(NUM_OUTPORTS) : 1
) (
    input  logic                     clk,
    input  logic                     rst,
    input  chiplet_types_pkg::flit_t head_flit,
    output logic [OUT_BITS-1:0]      outport,
    input  logic                     claim_valid,
    input  chiplet_types_pkg::flit_t claim_flit
);
    chiplet_types_pkg::route_entry_t route_table [chiplet_types_pkg::TABLE_SIZE];

    chiplet_types_pkg::table_index_t wr_index;
    chiplet_types_pkg::route_entry_t wr_entry;
    logic wr_en;

    // Entries are always below NUM_OUTPORTS, so narrowing is safe
    assign outport = OUT_BITS'(route_table[head_flit.dest]);

    // Decode the configuration payload
    always_comb begin
        wr_index = chiplet_types_pkg::cfg_index(claim_flit);
        wr_entry = chiplet_types_pkg::cfg_outport(claim_flit);
        // Nonexistent outport falls back to the local port
        if (int'(wr_entry) >= NUM_OUTPORTS) begin
            wr_entry = '0;
        end
    end

    // Only configuration aimed at this node may touch the table
    assign wr_en = claim_valid && (chiplet_types_pkg::cfg_target(claim_flit) == NODE);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < chiplet_types_pkg::TABLE_SIZE; i++) begin
                route_table[i] <= '0;
            end
        end else if (wr_en) begin
            route_table[wr_index] <= wr_entry;
        end
    end

endmodule

// ==== switch.sv ====
`timescale 1ns/1ps

module switch #(
    parameter int NUM_BUFFERS = 4,
    parameter int NUM_OUTPORTS = 4,
    parameter int BUFFER_SIZE = 4,
    parameter chiplet_types_pkg::node_id_t NODE = 5'd5
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  chiplet_types_pkg::flit_t [NUM_BUFFERS-1:0]  in,
    input  logic [NUM_BUFFERS-1:0]                      data_ready_in,
    output logic [NUM_BUFFERS-1:0]                      buffer_available,
    output chiplet_types_pkg::flit_t [NUM_OUTPORTS-1:0] out,
    output logic [NUM_OUTPORTS-1:0]                     data_ready_out,
    input  logic [NUM_OUTPORTS-1:0]                     out_ready
);
    localparam int OUT_BITS = (NUM_OUTPORTS > 1) ? $clog2(NUM_OUTPORTS) : 1;
    localparam int IDX_BITS = (NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1;

    logic rc_valid;
    logic [IDX_BITS-1:0] rc_select;
    logic sa_valid;
    logic [IDX_BITS-1:0] sa_index;
    logic [OUT_BITS-1:0] sa_outport;
    logic [NUM_OUTPORTS-1:0] xb_valid;
    logic cfg_claim;

    buffers_if #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS),
        .DEPTH(BUFFER_SIZE)
    ) buf_if ();

    buffers #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS),
        .DEPTH(BUFFER_SIZE)
    ) buffers_inst (
        .clk(clk),
        .rst(rst),
        .buf_if(buf_if)
    );

    // Inputs go straight into their own FIFO
    assign buf_if.wen = data_ready_in;
    assign buf_if.wdata = in;
    assign buffer_available = buf_if.available;

    // Routing stage picks one unrouted head per cycle
    arbiter #(
        .WIDTH(NUM_BUFFERS)
    ) rc_arbiter (
        .clk(clk),
        .rst(rst),
        .bid(buf_if.req_routing),
        .valid(rc_valid),
        .select(rc_select)
    );

    route_compute #(
        .NODE(NODE),
        .NUM_OUTPORTS(NUM_OUTPORTS)
    ) route_compute_inst (
        .clk(clk),
        .rst(rst),
        .head_flit(buf_if.rdata[rc_select]),
        .outport(buf_if.routing_outport),
        .claim_valid(cfg_claim),
        .claim_flit(out[0])
    );

    assign buf_if.routing_granted = NUM_BUFFERS'(rc_valid) << rc_select;

    switch_allocator #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS)
    ) switch_allocator_inst (
        .clk(clk),
        .rst(rst),
        .req_switch(buf_if.req_switch),
        .switch_outport(buf_if.switch_outport),
        .out_ready(out_ready),
        .grant(),
        .grant_valid(sa_valid),
        .grant_outport(sa_outport),
        .grant_index(sa_index)
    );

    crossbar #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS)
    ) crossbar_inst (
        .clk(clk),
        .rst(rst),
        .rdata(buf_if.rdata),
        .grant_valid(sa_valid),
        .grant_index(sa_index),
        .grant_outport(sa_outport),
        .ren(buf_if.ren),
        .out(out),
        .valid(xb_valid)
    );

    // Configuration for this node on the local port is consumed here
    assign cfg_claim = xb_valid[0]
        && (chiplet_types_pkg::flit_format(out[0]) == chiplet_types_pkg::FMT_SWITCH_CFG)
        && (chiplet_types_pkg::cfg_target(out[0]) == NODE);

    always_comb begin
        data_ready_out = xb_valid;
        data_ready_out[0] = xb_valid[0] && !cfg_claim;
    end

endmodule

// ==== switch_allocator.sv ====
`timescale 1ns/1ps

module switch_allocator #(
    parameter int NUM_BUFFERS = 4,
    parameter int NUM_OUTPORTS = 4,
    localparam int OUT_BITS = (NUM_OUTPORTS > 1) ? $clog2(NUM_OUTPORTS) : 1,
    localparam int IDX_BITS = (NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [NUM_BUFFERS-1:0]               req_switch,
    input  logic [NUM_BUFFERS-1:0][OUT_BITS-1:0] switch_outport,
    input  logic [NUM_OUTPORTS-1:0]              out_ready,
    output logic [NUM_BUFFERS-1:0]               grant,
    output logic                                 grant_valid,
    output logic [OUT_BITS-1:0]                  grant_outport,
    output logic [IDX_BITS-1:0]                  grant_index
);
    logic [NUM_BUFFERS-1:0] eligible;

    // Heads bound to a stalled outport sit out this round
    always_comb begin
        for (int b = 0; b < NUM_BUFFERS; b++) begin
            eligible[b] = req_switch[b] && out_ready[switch_outport[b]];
        end
    end

    arbiter #(
        .WIDTH(NUM_BUFFERS)
    ) sa_arbiter (
        .clk(clk),
        .rst(rst),
        .bid(eligible),
        .valid(grant_valid),
        .select(grant_index)
    );

    assign grant = NUM_BUFFERS'(grant_valid) << grant_index;
    assign grant_outport = switch_outport[grant_index];

endmodule

// ==== switch_if.sv ====
`timescale 1ns/1ps

interface buffers_if #(
    parameter int NUM_BUFFERS = 4,
    parameter int NUM_OUTPORTS = 4,
    parameter int DEPTH = 4
);
    localparam int OUT_BITS = (NUM_OUTPORTS > 1) ? $clog2(NUM_OUTPORTS) : 1;

    // Buffer side
    chiplet_types_pkg::flit_t [NUM_BUFFERS-1:0] rdata;
    logic [NUM_BUFFERS-1:0] empty;
    logic [NUM_BUFFERS-1:0] available;
    logic [NUM_BUFFERS-1:0] req_routing;
    logic [NUM_BUFFERS-1:0] req_switch;
    logic [NUM_BUFFERS-1:0][OUT_BITS-1:0] switch_outport;

    // Stage side
    logic [NUM_BUFFERS-1:0] wen;
    chiplet_types_pkg::flit_t [NUM_BUFFERS-1:0] wdata;
    logic [NUM_BUFFERS-1:0] routing_granted;
    logic [OUT_BITS-1:0] routing_outport;
    logic [NUM_BUFFERS-1:0] ren;

    // A buffer needs room for at least one flit
    if (DEPTH < 1 || NUM_BUFFERS < 1) begin : g_bad_size
        $error("buffers_if needs DEPTH and NUM_BUFFERS of at least 1");
    end

    modport buffers (
        output rdata, empty, available, req_routing, req_switch, switch_outport,
        input  wen, wdata, routing_granted, routing_outport, ren
    );

    modport stages (
        input  rdata, empty, available, req_routing, req_switch, switch_outport,
        output wen, wdata, routing_granted, routing_outport, ren
    );

endinterface

// ==== tb_switch.sv ====
`timescale 1ns/1ps

module tb_switch;
    typedef chiplet_types_pkg::flit_t flit_t;
    localparam int NUM_PORTS = 4;
    localparam chiplet_types_pkg::node_id_t NODE = 5'd5;

    logic clk;
    logic rst;
    flit_t [NUM_PORTS-1:0] flit_in;
    logic [NUM_PORTS-1:0] data_ready_in;
    logic [NUM_PORTS-1:0] buffer_available;
    flit_t [NUM_PORTS-1:0] flit_out;
    logic [NUM_PORTS-1:0] data_ready_out;
    logic [NUM_PORTS-1:0] out_ready;

    // One queue per (inport, outport) pair, index inport * NUM_PORTS + outport
    flit_t exp_q [NUM_PORTS*NUM_PORTS][$];
    logic [2:0] model_table [32];
    logic [15:0] lfsr;
    logic [NUM_PORTS-1:0] ready_at_edge;
    int sent_total;
    int cycle_count;
    bit saw_full;

    switch switch_inst (
        .clk(clk),
        .rst(rst),
        .in(flit_in),
        .data_ready_in(data_ready_in),
        .buffer_available(buffer_available),
        .out(flit_out),
        .data_ready_out(data_ready_out),
        .out_ready(out_ready)
    );

    bind switch tb_switch_assert #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS)
    ) switch_assert_inst (
        .clk(clk),
        .rst(rst),
        .data_ready_in(data_ready_in),
        .buffer_available(buffer_available),
        .data_ready_out(data_ready_out),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            // Galois form of x^16 + x^14 + x^13 + x^11 + 1
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic flit_t random_data_flit();
        flit_t f;
        f.dest = 5'(rand_bits(5));
        f.payload = rand_bits(32);
        // Keep data clear of the configuration format
        if (f.payload[31:28] == chiplet_types_pkg::FMT_SWITCH_CFG) begin
            f.payload[31:28] = 4'h3;
        end
        return f;
    endfunction

    function automatic flit_t config_flit(logic [4:0] dest, logic [4:0] target,
                                          logic [4:0] index, logic [2:0] port);
        flit_t f;
        f.dest = dest;
        f.payload = rand_bits(32);
        f.payload[31:28] = chiplet_types_pkg::FMT_SWITCH_CFG;
        f.payload[27:23] = target;
        f.payload[22:18] = index;
        f.payload[2:0] = port;
        return f;
    endfunction

    // Expected outport of a flit, or -1 when the switch keeps it
    function automatic int reference_route(flit_t f);
        int port;
        logic [2:0] entry;
        port = int'(model_table[f.dest]);
        if (port == 0 && f.payload[31:28] == chiplet_types_pkg::FMT_SWITCH_CFG
                && f.payload[27:23] == NODE) begin
            entry = f.payload[2:0];
            if (int'(entry) >= NUM_PORTS) begin
                entry = '0;
            end
            model_table[f.payload[22:18]] = entry;
            return -1;
        end
        return port;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        foreach (exp_q[k]) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Caller has already seen buffer_available high
    task automatic accept_flit(int i, flit_t f);
        int port;
        port = reference_route(f);
        flit_in[i] = f;
        data_ready_in[i] = 1'b1;
        if (port >= 0) begin
            exp_q[i*NUM_PORTS+port].push_back(f);
        end
        sent_total++;
    endtask

    task automatic send_one(int i, flit_t f);
        while (!buffer_available[i]) begin
            @(negedge clk);
        end
        accept_flit(i, f);
        @(negedge clk);
        data_ready_in = '0;
    endtask

    task automatic run_traffic(int count, bit stall);
        int sent;
        int cyc;
        sent = 0;
        cyc = 0;
        while (sent < count) begin
            data_ready_in = '0;
            if (stall) begin
                // Full stall first so every buffer fills
                if (cyc < 12) begin
                    out_ready = '0;
                end else if (cyc % 8 == 0) begin
                    out_ready = NUM_PORTS'(rand_bits(NUM_PORTS));
                end
            end
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (sent < count && buffer_available[i] && (stall || rand_bits(1) == 1)) begin
                    accept_flit(i, random_data_flit());
                    sent++;
                end
            end
            cyc++;
            @(negedge clk);
        end
        data_ready_in = '0;
        out_ready = '1;
    endtask

    task automatic wait_drain();
        while (pending() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_output(int o);
        int hit;
        int waiting;
        flit_t expected;
        hit = -1;
        waiting = 0;
        expected = '0;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            if (exp_q[i*NUM_PORTS+o].size() > 0) begin
                waiting++;
                expected = exp_q[i*NUM_PORTS+o][0];
                if (expected == flit_out[o]) begin
                    hit = i;
                end
            end
        end
        assert (ready_at_edge[o]) else begin
            $display("Fail at %0t: data_ready_out[%0d] expected 0, actual 1", $time, o);
            fail_run();
        end
        assert (waiting > 0) else begin
            $display("Outport %0d delivered a flit that no inport should send there", o);
            fail_run();
        end
        assert (hit >= 0) else begin
            $display("Fail at %0t: out[%0d] expected %h, actual %h",
                     $time, o, expected, flit_out[o]);
            fail_run();
        end
        void'(exp_q[hit*NUM_PORTS+o].pop_front());
    endtask

    // out_ready as seen by the allocator in the grant cycle
    always @(posedge clk) begin
        ready_at_edge <= out_ready;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (buffer_available != '1) begin
                saw_full = 1'b1;
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (data_ready_out[o]) begin
                    check_output(o);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 40 * sent_total + 200) begin
            $display("Timeout after %0d cycles with %0d flits still expected",
                     cycle_count, pending());
            fail_run();
        end
    end

    initial begin
        logic [4:0] other;
        flit_t marker;
        rst = 1'b1;
        flit_in = '0;
        data_ready_in = '0;
        out_ready = '1;
        lfsr = 16'd14;
        sent_total = 0;
        cycle_count = 0;
        saw_full = 1'b0;
        for (int d = 0; d < 32; d++) begin
            model_table[d] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Untouched table sends everything to outport 0
        run_traffic(24, 1'b0);
        wait_drain();

        // Configuration for other nodes passes through as data
        for (int k = 0; k < 8; k++) begin
            other = 5'(rand_bits(5));
            if (other == NODE) begin
                other = other + 1'b1;
            end
            send_one(k % NUM_PORTS, config_flit(5'(rand_bits(5)), other, 5'(rand_bits(5)),
                                                3'(rand_bits(3))));
        end
        run_traffic(8, 1'b0);
        wait_drain();

        // Entry 0 stays on the local port so every claim takes the same path
        for (int d = 1; d < 32; d++) begin
            send_one(0, config_flit(5'd0, NODE, 5'(d), 3'(rand_bits(3))));
        end
        // Marker arrives only after the last claim has hit the table
        marker = random_data_flit();
        marker.dest = '0;
        send_one(0, marker);
        wait_drain();

        run_traffic(200, 1'b0);
        wait_drain();

        saw_full = 1'b0;
        run_traffic(200, 1'b1);
        wait_drain();
        assert (saw_full) else begin
            $display("buffer_available never fell while the outports were stalled");
            fail_run();
        end

        // Idle window so a late duplicate delivery still reaches the checker
        repeat (10) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== tb_switch_assert.sv ====
`timescale 1ns/1ps

module tb_switch_assert #(
    parameter int NUM_BUFFERS = 4,
    parameter int NUM_OUTPORTS = 4
) (
    input logic                    clk,
    input logic                    rst,
    input logic [NUM_BUFFERS-1:0]  data_ready_in,
    input logic [NUM_BUFFERS-1:0]  buffer_available,
    input logic [NUM_OUTPORTS-1:0] data_ready_out,
    input logic [NUM_OUTPORTS-1:0] out_ready
);
    // Writes only land in a buffer with space
    for (genvar i = 0; i < NUM_BUFFERS; i++) begin : g_inport
        no_write_when_full: assert property (
            @(posedge clk) disable iff (rst) data_ready_in[i] |-> buffer_available[i]
        ) else $error("inport %0d strobed while its buffer was full", i);
    end

    // Grant cycle must have seen the outport ready
    for (genvar o = 0; o < NUM_OUTPORTS; o++) begin : g_outport
        ready_before_delivery: assert property (
            @(posedge clk) disable iff (rst) data_ready_out[o] |-> $past(out_ready[o])
        ) else $error("outport %0d delivered without out_ready in the grant cycle", o);
    end

    quiet_after_reset: assert property (
        @(posedge clk) $past(rst) |-> (data_ready_out == '0)
    ) else $error("data_ready_out active during or just after reset");

endmodule
